// ==== Makefile ====
# Verilator build and run for the LSPC timing subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= lspcTimingTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only when the simulation output holds the pass line
test: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

// ==== common/lspcPkg.sv ====
/*
 * Shared definitions for the LSPC timing subsystem
 * Width typedefs for raster, timer and APB signals
 * Register offsets and bit positions, timer state encoding
 */
`default_nettype none

package lspcPkg;

	// ====================
	// Widths
	// ====================

	// Horizontal position within a line, enough for 384 pixels
	typedef logic [8:0] pixelCountT;

	// Raster line number, enough for 264 lines
	typedef logic [8:0] lineCountT;

	// Raster timer count and its reload value, in pixel periods
	typedef logic [31:0] timerValueT;

	// Byte offset of a register inside the block
	typedef logic [3:0] apbAddrT;

	// APB data word
	typedef logic [31:0] apbDataT;

	// ====================
	// Register map
	// ====================

	localparam apbAddrT regCtrl = 4'h0;
	localparam apbAddrT regReload = 4'h4;
	// Reads give line and pending flags, writes acknowledge
	localparam apbAddrT regStatus = 4'h8;
	// Current timer value, read only
	localparam apbAddrT regCount = 4'hC;

	// Control register bits
	localparam int ctrlTimerEnBit = 0;
	localparam int ctrlAutoReloadBit = 1;
	localparam int ctrlVblankEnBit = 2;

	// Status register fields, the same bits acknowledge on a write
	localparam int statusTimerBit = 0;
	localparam int statusVblankBit = 1;
	localparam int statusLineLsb = 16;

	// Raster timer FSM states
	typedef enum logic [1:0]
	{
		timerIdle,
		timerRunning,
		timerExpired
	} timerStateT;

endpackage

`default_nettype wire

// ==== sim.f ====
common/lspcPkg.sv
source/lspcClockGen.sv
timing/lspcRasterCounter.sv
timing/lspcRasterTimer.sv
source/lspcApbRegs.sv
source/lspcTiming.sv
tests/lspcChecker.sv
tests/lspcTimingTb.sv

// ==== source/lspcApbRegs.sv ====
/*
 * APB register block for the raster timer and interrupts
 * Control, reload, status and count registers
 * Vertical-blank pending flag and the combined interrupt
 */
`default_nettype none

module lspcApbRegs
	import lspcPkg::*;
(
	input wire logic CLK_24M,
	input wire logic nRESETP,
	input wire apbAddrT paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	input wire lineCountT lineY,
	input wire logic vblankStart,
	input wire timerValueT timerCount,
	input wire logic timerPending,
	output logic timerEnable,
	output logic autoReload,
	output timerValueT reloadValue,
	output logic reloadWrite,
	output logic timerAck,
	output logic irq
);

	logic accessPhase;
	logic writeAccess;
	logic addrMapped;
	logic vblankIrqEnable;
	logic vblankPending;

	// ====================
	// Bus decode
	// ====================

	// Second cycle of a transfer, where the data is exchanged
	assign accessPhase = psel & penable;
	assign writeAccess = accessPhase & pwrite;

	// Only the four word offsets exist
	assign addrMapped = (paddr == regCtrl) | (paddr == regReload) |
		(paddr == regStatus) | (paddr == regCount);

	// No wait states in this block
	assign pready = 1'b1;

	// Unmapped offsets fail, and so does a write to the count
	assign pslverr = accessPhase & (~addrMapped | (pwrite & (paddr == regCount)));

	// ====================
	// Register writes
	// ====================

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			timerEnable <= 1'b0;
			autoReload <= 1'b0;
			vblankIrqEnable <= 1'b0;
			reloadValue <= '0;
			reloadWrite <= 1'b0;
			timerAck <= 1'b0;
		end
		else
		begin
			// Strobes to the timer last exactly one cycle
			reloadWrite <= writeAccess & (paddr == regReload);
			timerAck <= writeAccess & (paddr == regStatus) & pwdata[statusTimerBit];

			if (writeAccess && (paddr == regCtrl))
			begin
				timerEnable <= pwdata[ctrlTimerEnBit];
				autoReload <= pwdata[ctrlAutoReloadBit];
				vblankIrqEnable <= pwdata[ctrlVblankEnBit];
			end

			if (writeAccess && (paddr == regReload))
				reloadValue <= pwdata;
		end
	end

	// Vertical-blank flag lives here since the raster counter only pulses
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			vblankPending <= 1'b0;
		else if (vblankStart)
			vblankPending <= 1'b1;
		else if (writeAccess && (paddr == regStatus) && pwdata[statusVblankBit])
			vblankPending <= 1'b0;
	end

	// ====================
	// Readback and interrupt
	// ====================

	always_comb
	begin
		prdata = '0;
		case (paddr)
			regCtrl:
			begin
				prdata[ctrlTimerEnBit] = timerEnable;
				prdata[ctrlAutoReloadBit] = autoReload;
				prdata[ctrlVblankEnBit] = vblankIrqEnable;
			end
			regReload:
				prdata = reloadValue;
			regStatus:
			begin
				prdata[statusTimerBit] = timerPending;
				prdata[statusVblankBit] = vblankPending;
				prdata[statusLineLsb +: $bits(lineCountT)] = lineY;
			end
			regCount:
				prdata = timerCount;
			default:
				prdata = '0;
		endcase
	end

	// The vertical-blank source is masked, the timer source is not
	assign irq = timerPending | (vblankPending & vblankIrqEnable);

endmodule

`default_nettype wire

// ==== source/lspcClockGen.sv ====
/*
 * Clock enable generator running from the 24 MHz board clock
 * Binary phase divider for the 12, 6, 3 and 1.5 MHz enables
 * Divide-by-three pair for 8 MHz, halved again for 4 MHz
 */
`default_nettype none

module lspcClockGen
(
	input wire logic CLK_24M,
	input wire logic nRESETP,
	output logic en12m,
	output logic en8m,
	output logic en6m,
	output logic en4m,
	output logic en3m,
	output logic en1m5
);

	// Free-running 4-bit phase, each bit is one binary sub-rate
	logic [3:0] phaseCount;
	logic [3:0] phaseNext;

	// Two-flop divide-by-three, the pair steps 00, 01, 10 and back to 00
	logic div3A;
	logic div3B;
	logic en8mNext;

	// Flips on every 8 MHz enable to pick every second one for 4 MHz
	logic div4Toggle;

	assign phaseNext = phaseCount + 4'd1;

	// The pair sits at 10 just before it returns to 00
	assign en8mNext = div3A & ~div3B;

	// ====================
	// Binary divider
	// ====================

	// Enables are decoded from the next phase so they are registered
	// and line up with the phase value they belong to
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			// Phase 2 keeps every decode low while reset is held
			phaseCount <= 4'd2;
			en12m <= 1'b0;
			en6m <= 1'b0;
			en3m <= 1'b0;
			en1m5 <= 1'b0;
		end
		else
		begin
			phaseCount <= phaseNext;
			en12m <= phaseNext[0];
			en6m <= (phaseNext[1:0] == 2'b11);
			en3m <= (phaseNext[2:0] == 3'b111);
			en1m5 <= (phaseNext == 4'hF);
		end
	end

	// ====================
	// Divide by three
	// ====================

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			div3A <= 1'b0;
			div3B <= 1'b0;
			div4Toggle <= 1'b0;
			en8m <= 1'b0;
			en4m <= 1'b0;
		end
		else
		begin
			// Each flop toggles only while the other one allows it
			div3A <= div3B ? ~div3A : 1'b0;
			div3B <= ~div3A ? ~div3B : 1'b0;
			en8m <= en8mNext;
			// 4 MHz takes the second of each pair of 8 MHz pulses
			en4m <= en8mNext & div4Toggle;
			if (en8mNext)
				div4Toggle <= ~div4Toggle;
		end
	end

endmodule

`default_nettype wire

// ==== source/lspcTiming.sv ====
/*
 * Top level of the video timing and interrupt subsystem
 * Clock enables, raster counter, raster timer and APB registers
 */
`default_nettype none

module lspcTiming
	import lspcPkg::*;
#(
	parameter int hTotal = 384,
	parameter int hActive = 320,
	parameter int hSyncWidth = 32,
	parameter int vTotal = 264,
	parameter int vActive = 224,
	parameter int vSyncWidth = 8
)
(
	input wire logic CLK_24M,
	input wire logic nRESETP,
	input wire apbAddrT paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	output logic pixelEnable,
	output logic clk8mEnable,
	output pixelCountT pixelX,
	output lineCountT lineY,
	output logic hBlank,
	output logic hSync,
	output logic vBlank,
	output logic vSync,
	output logic irq
);

	logic en6m;
	logic en8m;
	logic vblankStart;
	logic timerEnable;
	logic autoReload;
	logic reloadWrite;
	logic timerAck;
	logic timerPending;
	timerValueT reloadValue;
	timerValueT timerCount;

	// The pixel and 8 MHz enables also feed the rest of the chip
	assign pixelEnable = en6m;
	assign clk8mEnable = en8m;

	// ====================
	// Blocks
	// ====================

	// The slower rates are left open until other blocks need them
	lspcClockGen clockGen
	(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.en12m(),
		.en8m(en8m),
		.en6m(en6m),
		.en4m(),
		.en3m(),
		.en1m5()
	);

	lspcRasterCounter #(
		.hTotal(hTotal),
		.hActive(hActive),
		.hSyncWidth(hSyncWidth),
		.vTotal(vTotal),
		.vActive(vActive),
		.vSyncWidth(vSyncWidth)
	) rasterCounter
	(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.en6m(en6m),
		.pixelX(pixelX),
		.lineY(lineY),
		.hBlank(hBlank),
		.hSync(hSync),
		.vBlank(vBlank),
		.vSync(vSync),
		.vblankStart(vblankStart)
	);

	lspcRasterTimer rasterTimer
	(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.en6m(en6m),
		.timerEnable(timerEnable),
		.autoReload(autoReload),
		.reloadValue(reloadValue),
		.reloadWrite(reloadWrite),
		.timerAck(timerAck),
		.timerCount(timerCount),
		.timerPending(timerPending)
	);

	lspcApbRegs apbRegs
	(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.lineY(lineY),
		.vblankStart(vblankStart),
		.timerCount(timerCount),
		.timerPending(timerPending),
		.timerEnable(timerEnable),
		.autoReload(autoReload),
		.reloadValue(reloadValue),
		.reloadWrite(reloadWrite),
		.timerAck(timerAck),
		.irq(irq)
	);

endmodule

`default_nettype wire

// ==== tests/lspcChecker.sv ====
/*
 * Testbench monitor for the LSPC timing subsystem
 * Enable cadence and raster position models stepped from reset
 * APB read data, bus error and irq level comparison, result counts
 */
`default_nettype none

module lspcChecker
	import lspcPkg::*;
#(
	parameter int hTotal = 40,
	parameter int hActive = 32,
	parameter int hSyncWidth = 4,
	parameter int vTotal = 12,
	parameter int vActive = 8,
	parameter int vSyncWidth = 2
)
(
	input wire logic CLK_24M,
	input wire logic nRESETP,
	input wire logic pixelEnable,
	input wire logic clk8mEnable,
	input wire pixelCountT pixelX,
	input wire lineCountT lineY,
	input wire logic hBlank,
	input wire logic hSync,
	input wire logic vBlank,
	input wire logic vSync,
	input wire logic irq,
	input wire logic psel,
	input wire logic penable,
	input wire apbDataT prdata,
	input wire logic pready,
	input wire logic pslverr,
	input wire logic busCheck,
	input wire apbDataT expData,
	input wire apbDataT expMask,
	input wire logic expErr,
	input wire logic irqCheck,
	input wire logic expIrq
);

	timeunit 1ns;
	timeprecision 100ps;

	// Window edges as position values, taken straight from the raster rules
	localparam pixelCountT hLastM = pixelCountT'(hTotal - 1);
	localparam lineCountT vLastM = lineCountT'(vTotal - 1);
	localparam pixelCountT hBlankM = pixelCountT'(hActive);
	localparam pixelCountT hSyncM = pixelCountT'(hTotal - hSyncWidth);
	localparam lineCountT vBlankM = lineCountT'(vActive);
	localparam lineCountT vSyncM = lineCountT'(vTotal - vSyncWidth);

	// Cadence is watched over this many cycles after reset release
	localparam int cadenceCycles = 240;

	int cycleCount;
	int pixelsSeen;
	int cadenceErrors;
	int rasterErrors;
	int testErrors;
	int passCount;
	int failCount;
	bit cadenceDone;
	bit rasterDone;
	string testName;
	pixelCountT modelX;
	lineCountT modelY;
	logic [3:0] expRaster;
	logic [3:0] actRaster;

	initial
	begin
		pixelsSeen = 0;
		cadenceErrors = 0;
		rasterErrors = 0;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		cadenceDone = 0;
		rasterDone = 0;
		testName = "none";
		modelX = '0;
		modelY = '0;
	end

	// One result line per finished test
	task automatic report(input string name, input int errors);
		if (errors == 0)
		begin
			passCount++;
			$display("%s: passed", name);
		end
		else
		begin
			failCount++;
			$display("%s: failed with %0d errors", name, errors);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		report(testName, testErrors);
	endtask

	// Cycle 1 is the first cycle after the first edge that sees reset released
	always @(posedge CLK_24M)
	begin
		if (!nRESETP)
			cycleCount <= 0;
		else
			cycleCount <= cycleCount + 1;
	end

	// ====================
	// Enable cadence
	// ====================

	// Outputs are sampled on the falling edge where they are settled
	always @(negedge CLK_24M)
	begin
		if (nRESETP && !cadenceDone)
		begin
			if (pixelEnable !== (cycleCount % 4 == 1))
			begin
				cadenceErrors++;
				$display("error: enable_cadence pixelEnable expected %0b actual %0b cycle %0d",
					(cycleCount % 4 == 1), pixelEnable, cycleCount);
			end
			if (clk8mEnable !== (cycleCount > 0 && cycleCount % 3 == 0))
			begin
				cadenceErrors++;
				$display("error: enable_cadence clk8mEnable expected %0b actual %0b cycle %0d",
					(cycleCount > 0 && cycleCount % 3 == 0), clk8mEnable, cycleCount);
			end
			if (cycleCount >= cadenceCycles)
			begin
				cadenceDone = 1;
				report("enable_cadence", cadenceErrors);
			end
		end
	end

	// ====================
	// Raster model
	// ====================

	always @(negedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			modelX = '0;
			modelY = '0;
		end
		else if (!rasterDone)
		begin
			// Order is hBlank, hSync, vBlank, vSync
			expRaster = {modelX >= hBlankM, modelX >= hSyncM,
				modelY >= vBlankM, modelY >= vSyncM};
			actRaster = {hBlank, hSync, vBlank, vSync};
			if (pixelX !== modelX || lineY !== modelY || actRaster !== expRaster)
			begin
				rasterErrors++;
				$display("error: raster_decode x/y/flags expected %0d/%0d/%b actual %0d/%0d/%b",
					modelX, modelY, expRaster, pixelX, lineY, actRaster);
			end
			// The counters step on the edge that samples the enable
			if (pixelEnable)
			begin
				pixelsSeen++;
				if (modelX == hLastM)
				begin
					modelX = '0;
					modelY = (modelY == vLastM) ? '0 : modelY + lineCountT'(1);
				end
				else
					modelX = modelX + pixelCountT'(1);
				if (pixelsSeen == 2 * hTotal * vTotal)
				begin
					rasterDone = 1;
					report("raster_decode", rasterErrors);
				end
			end
		end
	end

	// ====================
	// Bus and irq
	// ====================

	always @(negedge CLK_24M)
	begin
		if (busCheck && psel && penable)
		begin
			if ((prdata & expMask) !== expData)
			begin
				testErrors++;
				$display("error: %s prdata expected 0x%08h actual 0x%08h",
					testName, expData, prdata & expMask);
			end
			if (pslverr !== expErr)
			begin
				testErrors++;
				$display("error: %s pslverr expected %0b actual %0b", testName, expErr, pslverr);
			end
			// Every transfer completes without wait states
			if (pready !== 1'b1)
			begin
				testErrors++;
				$display("error: %s pready expected 1 actual %0b", testName, pready);
			end
		end
		if (irqCheck && irq !== expIrq)
		begin
			testErrors++;
			$display("error: %s irq expected %0b actual %0b", testName, expIrq, irq);
		end
	end

endmodule

`default_nettype wire

// ==== tests/lspcTimingTb.sv ====
/*
 * Testbench top for the LSPC timing subsystem
 * Clock, reset, trace driven APB transfers and the watchdog
 */
`default_nettype none

module lspcTimingTb;

	import lspcPkg::*;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int hTotal = 40;
	localparam int vTotal = 12;
	localparam int frame = hTotal * vTotal;
	localparam int driveDelay = 1;
	localparam string traceFile = "tests/lspcTimingTrace.txt";

	logic CLK_24M;
	logic nRESETP;
	apbAddrT paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apbDataT pwdata;
	apbDataT prdata;
	logic pready;
	logic pslverr;
	logic pixelEnable;
	logic clk8mEnable;
	pixelCountT pixelX;
	lineCountT lineY;
	logic hBlank;
	logic hSync;
	logic vBlank;
	logic vSync;
	logic irq;
	logic busCheck;
	apbDataT expData;
	apbDataT expMask;
	logic expErr;
	logic irqCheck;
	logic expIrq;
	int limitNs;

	// 4 ns period
	initial CLK_24M = 1'b0;
	always #2 CLK_24M = ~CLK_24M;

	lspcTiming #(
		.hTotal(hTotal), .hActive(32), .hSyncWidth(4),
		.vTotal(vTotal), .vActive(8), .vSyncWidth(2)
	) dut
	(
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.pixelEnable(pixelEnable), .clk8mEnable(clk8mEnable),
		.pixelX(pixelX), .lineY(lineY), .hBlank(hBlank), .hSync(hSync),
		.vBlank(vBlank), .vSync(vSync), .irq(irq)
	);

	lspcChecker #(
		.hTotal(hTotal), .hActive(32), .hSyncWidth(4),
		.vTotal(vTotal), .vActive(8), .vSyncWidth(2)
	) checkUnit
	(
		.CLK_24M(CLK_24M), .nRESETP(nRESETP),
		.pixelEnable(pixelEnable), .clk8mEnable(clk8mEnable),
		.pixelX(pixelX), .lineY(lineY), .hBlank(hBlank), .hSync(hSync),
		.vBlank(vBlank), .vSync(vSync), .irq(irq),
		.psel(psel), .penable(penable), .prdata(prdata), .pready(pready),
		.pslverr(pslverr),
		.busCheck(busCheck), .expData(expData), .expMask(expMask), .expErr(expErr),
		.irqCheck(irqCheck), .expIrq(expIrq)
	);

	// One APB transfer, setup then access, with the expected response
	task automatic transfer(input logic [31:0] addr, input logic wr, input logic [31:0] data,
		input logic [31:0] expValue, input logic [31:0] mask, input logic err);
		paddr = apbAddrT'(addr);
		pwrite = wr;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge CLK_24M);
		#driveDelay;
		penable = 1'b1;
		busCheck = 1'b1;
		expData = expValue;
		expMask = mask;
		expErr = err;
		@(posedge CLK_24M);
		#driveDelay;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		busCheck = 1'b0;
	endtask

	// Counts edges that carry a pixel enable, seen on the falling edge before
	task automatic waitPixels(input int count);
		repeat (count)
		begin
			do
				@(negedge CLK_24M);
			while (!pixelEnable);
			@(posedge CLK_24M);
		end
		#driveDelay;
	endtask

	task automatic waitLine(input int line);
		do
			@(negedge CLK_24M);
		while (lineY != lineCountT'(line));
		@(posedge CLK_24M);
		#driveDelay;
	endtask

	task automatic checkIrq(input int level);
		irqCheck = 1'b1;
		expIrq = (level != 0);
		@(posedge CLK_24M);
		#driveDelay;
		irqCheck = 1'b0;
	endtask

	// ====================
	// Watchdog
	// ====================

	// Budget comes from the trace waits plus a margin per line
	initial
	begin
		int fd;
		int n;
		int pixelSum;
		int lines;
		string line;
		string cmd;
		pixelSum = 2 * frame;
		lines = 0;
		fd = $fopen(traceFile, "r");
		if (fd != 0)
		begin
			while ($fgets(line, fd))
			begin
				n = 0;
				if ($sscanf(line, "%s %d", cmd, n) >= 1 && cmd != "#")
				begin
					lines++;
					if (cmd == "P")
						pixelSum += n;
					else if (cmd == "L")
						pixelSum += frame;
				end
			end
			$fclose(fd);
		end
		limitNs = pixelSum * 16 + lines * 40 + 200;
		#(limitNs);
		$display("Watchdog expired, the run did not finish within %0d ns", limitNs);
		$display("Test FAILED");
		$finish;
	end

	// ====================
	// Trace runner
	// ====================

	initial
	begin
		int fd;
		int n;
		bit inTest;
		string line;
		string cmd;
		string name;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] m;
		logic [31:0] e;
		nRESETP = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		busCheck = 1'b0;
		expData = '0;
		expMask = '0;
		expErr = 1'b0;
		irqCheck = 1'b0;
		expIrq = 1'b0;
		inTest = 0;
		repeat (16) @(posedge CLK_24M);
		#driveDelay;
		nRESETP = 1'b1;
		fd = $fopen(traceFile, "r");
		if (fd == 0)
			$display("Could not open the trace file %s", traceFile);
		else
		begin
			while ($fgets(line, fd))
			begin
				if ($sscanf(line, "%s", cmd) < 1 || cmd == "#")
					continue;
				if (cmd == "T")
				begin
					void'($sscanf(line, "%s %s", cmd, name));
					if (inTest)
						checkUnit.endTest();
					checkUnit.startTest(name);
					inTest = 1;
				end
				else if (cmd == "W")
				begin
					void'($sscanf(line, "%s %h %h %h", cmd, a, d, e));
					transfer(a, 1'b1, d, '0, '0, e[0]);
				end
				else if (cmd == "R")
				begin
					void'($sscanf(line, "%s %h %h %h %h", cmd, a, d, m, e));
					transfer(a, 1'b0, '0, d, m, e[0]);
				end
				else if (cmd == "P")
				begin
					void'($sscanf(line, "%s %d", cmd, n));
					waitPixels(n);
				end
				else if (cmd == "L")
				begin
					void'($sscanf(line, "%s %d", cmd, n));
					waitLine(n);
				end
				else if (cmd == "I")
				begin
					void'($sscanf(line, "%s %d", cmd, n));
					checkIrq(n);
				end
			end
			$fclose(fd);
			if (inTest)
				checkUnit.endTest();
		end
		// Both frame models must have run to the end
		wait (checkUnit.rasterDone && checkUnit.cadenceDone);
		$display("Tests passed: %0d, failed: %0d", checkUnit.passCount, checkUnit.failCount);
		if (fd != 0 && checkUnit.failCount == 0 && checkUnit.passCount > 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/lspcTimingTrace.txt ====
# T name | W addr data err | R addr expected mask err | P pixels | L line | I irq
# Values in hex for W and R, decimal for P, L and I
T timer_oneshot
W 4 5 0
W 0 1 0
P 6
I 1
R 8 1 1 0
R C 0 FFFFFFFF 0
W 8 1 0
P 1
I 0
W 0 0 0
T timer_autoreload
W 4 3 0
W 0 3 0
P 4
I 1
W 8 1 0
P 1
I 0
P 3
I 1
W 8 1 0
P 1
I 0
P 3
I 1
W 0 0 0
W 8 1 0
T vblank_irq
W 0 4 0
L 0
W 8 2 0
P 1
I 0
L 8
P 2
I 1
R 8 2 2 0
W 8 2 0
P 1
I 0
T vblank_masked
W 0 0 0
L 0
W 8 2 0
P 480
I 0
T bus_errors
R 2 0 FFFFFFFF 1
R 6 0 FFFFFFFF 1
W 6 12345678 1
W C 55 1
R 4 3 FFFFFFFF 0
R 0 0 FFFFFFFF 0
T idle_frames
P 600
I 0

// ==== timing/lspcRasterCounter.sv ====
/*
 * Raster position counter stepped at the 6 MHz pixel rate
 * Blanking and sync decode from the pixel and line counters
 * One-cycle pulse at the start of vertical blank
 */
`default_nettype none

module lspcRasterCounter
	import lspcPkg::*;
#(
	parameter int hTotal = 384,
	parameter int hActive = 320,
	parameter int hSyncWidth = 32,
	parameter int vTotal = 264,
	parameter int vActive = 224,
	parameter int vSyncWidth = 8
)
(
	input wire logic CLK_24M,
	input wire logic nRESETP,
	input wire logic en6m,
	output pixelCountT pixelX,
	output lineCountT lineY,
	output logic hBlank,
	output logic hSync,
	output logic vBlank,
	output logic vSync,
	output logic vblankStart
);

	// ====================
	// Window limits
	// ====================

	// Last pixel of a line and last line of a frame
	localparam pixelCountT hLast = pixelCountT'(hTotal - 1);
	localparam lineCountT vLast = lineCountT'(vTotal - 1);

	// Sync pulses sit at the very end of each period
	localparam pixelCountT hSyncStart = pixelCountT'(hTotal - hSyncWidth);
	localparam lineCountT vSyncStart = lineCountT'(vTotal - vSyncWidth);

	// Blanking starts right after the visible area
	localparam pixelCountT hBlankStart = pixelCountT'(hActive);
	localparam lineCountT vBlankStart = lineCountT'(vActive);

	// The line before blank, where the wrap brings lineY into blank
	localparam lineCountT vBlankPrev = lineCountT'(vActive - 1);

	logic lastPixel;
	logic lastLine;

	assign lastPixel = (pixelX == hLast);
	assign lastLine = (lineY == vLast);

	// ====================
	// Counters
	// ====================

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			pixelX <= '0;
			lineY <= '0;
			vblankStart <= 1'b0;
		end
		else
		begin
			// Fires in the cycle right after lineY turns to vActive
			vblankStart <= en6m & lastPixel & (lineY == vBlankPrev);

			if (en6m)
			begin
				if (lastPixel)
				begin
					pixelX <= '0;
					// The line steps only when a line is complete
					if (lastLine)
						lineY <= '0;
					else
						lineY <= lineY + lineCountT'(1);
				end
				else
				begin
					pixelX <= pixelX + pixelCountT'(1);
				end
			end
		end
	end

	// ====================
	// Decode
	// ====================

	// Plain compares on the counter registers, so the windows
	// move on the same edge as the position
	assign hBlank = (pixelX >= hBlankStart);
	assign hSync = (pixelX >= hSyncStart);
	assign vBlank = (lineY >= vBlankStart);
	assign vSync = (lineY >= vSyncStart);

endmodule

`default_nettype wire

// ==== timing/lspcRasterTimer.sv ====
/*
 * Programmable raster timer counting pixel periods
 * Idle, running and expired FSM around a 32-bit down counter
 * Pending interrupt flag with acknowledge
 */
`default_nettype none

module lspcRasterTimer
	import lspcPkg::*;
(
	input wire logic CLK_24M,
	input wire logic nRESETP,
	input wire logic en6m,
	input wire logic timerEnable,
	input wire logic autoReload,
	input wire timerValueT reloadValue,
	input wire logic reloadWrite,
	input wire logic timerAck,
	output timerValueT timerCount,
	output logic timerPending
);

	timerStateT timerState;

	// A pixel period that finds the counter already at zero
	logic expireHit;

	// A reload from software always beats an expiry in the same cycle
	assign expireHit = (timerState == timerRunning) & timerEnable & en6m &
		(timerCount == '0) & ~reloadWrite;

	// ====================
	// Counter FSM
	// ====================

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			timerState <= timerIdle;
			timerCount <= '0;
		end
		else
		begin
			case (timerState)
				timerIdle:
				begin
					// Nothing to count until a value is loaded
					if (reloadWrite)
					begin
						timerState <= timerRunning;
						timerCount <= reloadValue;
					end
				end

				timerRunning:
				begin
					if (reloadWrite)
					begin
						timerCount <= reloadValue;
					end
					else if (expireHit)
					begin
						// Auto-reload restarts, otherwise park at zero
						if (autoReload)
							timerCount <= reloadValue;
						else
							timerState <= timerExpired;
					end
					else if (timerEnable && en6m)
					begin
						timerCount <= timerCount - timerValueT'(1);
					end
				end

				timerExpired:
				begin
					// Count holds at zero until software reloads
					if (reloadWrite)
					begin
						timerState <= timerRunning;
						timerCount <= reloadValue;
					end
				end

				default:
				begin
					timerState <= timerIdle;
					timerCount <= '0;
				end
			endcase
		end
	end

	// ====================
	// Pending flag
	// ====================

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			timerPending <= 1'b0;
		else if (expireHit)
			// A new expiry wins over an acknowledge in the same cycle
			timerPending <= 1'b1;
		else if (timerAck)
			timerPending <= 1'b0;
	end

endmodule

`default_nettype wire
